// File: common/mem_pkg.sv
package mem_pkg;

  ////////////////////////////////////////
  // Memory port geometry
  ////////////////////////////////////////

  localparam int unsigned MemAddrWidth = 32;
  localparam int unsigned MemIdWidth   = 4;
  localparam int unsigned MemDataWidth = 64;

  typedef logic [MemAddrWidth-1:0] mem_addr_t;
  typedef logic [MemIdWidth-1:0]   mem_id_t;
  typedef logic [MemDataWidth-1:0] mem_data_t;

  // Single-beat read request
  typedef struct packed {
    mem_addr_t addr;
    mem_id_t   id;
  } mem_req_t;

  // Read response whose id echoes the request
  typedef struct packed {
    mem_data_t data;
    mem_id_t   id;
  } mem_rsp_t;

  ////////////////////////////////////////
  // Transaction ID rule
  ////////////////////////////////////////

  // Instruction side owns the top id bit and data side keeps it clear
  localparam mem_id_t ICacheRdId = {1'b1, {(MemIdWidth - 1){1'b0}}};

  // Response belongs to the instruction side
  function automatic logic is_icache_id(mem_id_t id);
    return id[MemIdWidth-1];
  endfunction

endpackage

// File: common/cache_cfg_pkg.sv
package cache_cfg_pkg;

  ////////////////////////////////////////
  // Instruction cache address split
  ////////////////////////////////////////

  // Physical address width seen by the fetch side
  localparam int unsigned PaWidth    = 32;

  // Index plus line offset bits
  localparam int unsigned IndexWidth = 12;

  // Remaining upper bits form the tag
  localparam int unsigned TagWidth   = PaWidth - IndexWidth;

  typedef logic [TagWidth-1:0] tag_t;

  ////////////////////////////////////////
  // Default cacheable region
  ////////////////////////////////////////

  // Main memory window with device space all around it
  localparam logic [PaWidth-1:0] DefCachedBase = 32'h8000_0000;
  localparam logic [PaWidth-1:0] DefCachedSize = 32'h4000_0000;

endpackage

// File: mem_arbiter/mem_fifo.sv
`timescale 1ns/100ps

module mem_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  assign in_ready_o  = (cnt_q != 2'd2);
  assign out_valid_o = (cnt_q != 2'd0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

endmodule

// File: mem_arbiter/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Instruction side request
  input  logic                 ic_valid_i,
  output logic                 ic_ready_o,
  input  mem_pkg::mem_req_t    ic_req_i,
  // Data side request
  input  logic                 dc_valid_i,
  output logic                 dc_ready_o,
  input  mem_pkg::mem_req_t    dc_req_i,
  // Merged request toward memory
  output logic                 req_valid_o,
  input  logic                 req_ready_i,
  output mem_pkg::mem_req_t    req_o,
  // Response from memory
  input  logic                 rsp_valid_i,
  output logic                 rsp_ready_o,
  input  mem_pkg::mem_rsp_t    rsp_i,
  // Instruction side response
  output logic                 ic_rsp_valid_o,
  input  logic                 ic_rsp_ready_i,
  output mem_pkg::mem_rsp_t    ic_rsp_o,
  // Data side response
  output logic                 dc_rsp_valid_o,
  input  logic                 dc_rsp_ready_i,
  output mem_pkg::mem_rsp_t    dc_rsp_o
);

  import mem_pkg::*;

  // High when the data side wins the next tie
  logic prio_dc_q;
  // Grant frozen while a granted request stalls
  logic lock_q;
  logic lock_dc_q;
  logic sel_dc;
  logic req_fire;
  logic rsp_to_ic;

  ////////////////////////////////////////
  // Request arbitration
  ////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      sel_dc = lock_dc_q;
    end else if (ic_valid_i && dc_valid_i) begin
      sel_dc = prio_dc_q;
    end else begin
      sel_dc = dc_valid_i;
    end
  end

  assign req_valid_o = sel_dc ? dc_valid_i : ic_valid_i;
  assign ic_ready_o  = !sel_dc && req_ready_i;
  assign dc_ready_o  = sel_dc && req_ready_i;
  assign req_fire    = req_valid_o && req_ready_i;

  // Instruction side always goes out with its own id
  always_comb begin
    if (sel_dc) begin
      req_o = dc_req_i;
    end else begin
      req_o.addr = ic_req_i.addr;
      req_o.id   = ICacheRdId;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_dc_q <= 1'b0;
      lock_q    <= 1'b0;
      lock_dc_q <= 1'b0;
    end else begin
      if (req_fire) begin
        // Other side first on the next tie
        prio_dc_q <= !sel_dc;
        lock_q    <= 1'b0;
      end else if (req_valid_o) begin
        lock_q    <= 1'b1;
        lock_dc_q <= sel_dc;
      end
    end
  end

  ////////////////////////////////////////
  // Response demultiplexing
  ////////////////////////////////////////

  assign rsp_to_ic = is_icache_id(rsp_i.id);

  assign ic_rsp_valid_o = rsp_valid_i && rsp_to_ic;
  assign dc_rsp_valid_o = rsp_valid_i && !rsp_to_ic;
  assign rsp_ready_o    = rsp_to_ic ? ic_rsp_ready_i : dc_rsp_ready_i;

  assign ic_rsp_o = rsp_i;
  assign dc_rsp_o = rsp_i;

endmodule

// File: src/icache_route.sv
`timescale 1ns/100ps

module icache_route #(
  parameter mem_pkg::mem_addr_t CachedBase = cache_cfg_pkg::DefCachedBase,
  parameter mem_pkg::mem_addr_t CachedSize = cache_cfg_pkg::DefCachedSize
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Fetch address
  input  logic                 fetch_req_i,
  input  mem_pkg::mem_addr_t   fetch_addr_i,
  // Instruction side requests
  input  logic                 ic_miss_valid_i,
  output logic                 ic_miss_ready_o,
  input  mem_pkg::mem_req_t    ic_miss_i,
  input  logic                 ic_uc_valid_i,
  output logic                 ic_uc_ready_o,
  input  mem_pkg::mem_req_t    ic_uc_i,
  // Instruction side responses
  output logic                 ic_miss_rsp_valid_o,
  output logic                 ic_uc_rsp_valid_o,
  input  logic                 ic_rsp_ready_i,
  output mem_pkg::mem_rsp_t    ic_rsp_o,
  // Toward the arbiter
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output mem_pkg::mem_req_t    out_req_o,
  input  logic                 in_rsp_valid_i,
  output logic                 in_rsp_ready_o,
  input  mem_pkg::mem_rsp_t    in_rsp_i
);

  import mem_pkg::*;
  import cache_cfg_pkg::*;

  // One bit wider so the region end cannot wrap
  localparam logic [MemAddrWidth:0] RegionEnd = {1'b0, CachedBase} + {1'b0, CachedSize};

  tag_t               tag_d, tag_q;
  logic [PaWidth-1:0] fetch_pa;
  logic               paddr_is_nc;

  ////////////////////////////////////////
  // Tag capture and region check
  ////////////////////////////////////////

  // Live tag during a request and the last one seen otherwise
  assign tag_d = fetch_req_i ? fetch_addr_i[IndexWidth +: TagWidth] : tag_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_d;
    end
  end

  assign fetch_pa    = {tag_d, {IndexWidth{1'b0}}};
  assign paddr_is_nc = (fetch_pa < CachedBase) || ({1'b0, fetch_pa} >= RegionEnd);

  ////////////////////////////////////////
  // Channel steering
  ////////////////////////////////////////

  always_comb begin
    if (paddr_is_nc) begin
      out_valid_o         = ic_uc_valid_i;
      out_req_o           = ic_uc_i;
      ic_uc_ready_o       = out_ready_i;
      ic_miss_ready_o     = 1'b0;
      ic_uc_rsp_valid_o   = in_rsp_valid_i;
      ic_miss_rsp_valid_o = 1'b0;
    end else begin
      out_valid_o         = ic_miss_valid_i;
      out_req_o           = ic_miss_i;
      ic_miss_ready_o     = out_ready_i;
      ic_uc_ready_o       = 1'b0;
      ic_miss_rsp_valid_o = in_rsp_valid_i;
      ic_uc_rsp_valid_o   = 1'b0;
    end
  end

  // Both response channels share payload and ready
  assign ic_rsp_o       = in_rsp_i;
  assign in_rsp_ready_o = ic_rsp_ready_i;

endmodule

// File: src/refill_subsys.sv
`timescale 1ns/100ps

module refill_subsys #(
  parameter mem_pkg::mem_addr_t CachedBase = cache_cfg_pkg::DefCachedBase,
  parameter mem_pkg::mem_addr_t CachedSize = cache_cfg_pkg::DefCachedSize
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Fetch side
  input  logic                 fetch_req_i,
  input  mem_pkg::mem_addr_t   fetch_addr_i,
  // Instruction miss and uncached reads
  input  logic                 ic_miss_valid_i,
  output logic                 ic_miss_ready_o,
  input  mem_pkg::mem_req_t    ic_miss_i,
  input  logic                 ic_uc_valid_i,
  output logic                 ic_uc_ready_o,
  input  mem_pkg::mem_req_t    ic_uc_i,
  output logic                 ic_miss_rsp_valid_o,
  output logic                 ic_uc_rsp_valid_o,
  input  logic                 ic_rsp_ready_i,
  output mem_pkg::mem_rsp_t    ic_rsp_o,
  // Data cache miss
  input  logic                 dc_miss_valid_i,
  output logic                 dc_miss_ready_o,
  input  mem_pkg::mem_req_t    dc_miss_i,
  output logic                 dc_rsp_valid_o,
  input  logic                 dc_rsp_ready_i,
  output mem_pkg::mem_rsp_t    dc_rsp_o,
  // Memory port
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output mem_pkg::mem_req_t    mem_req_o,
  input  logic                 mem_rsp_valid_i,
  output logic                 mem_rsp_ready_o,
  input  mem_pkg::mem_rsp_t    mem_rsp_i
);

  import mem_pkg::*;

  // Router to arbiter
  logic     route_req_valid;
  logic     route_req_ready;
  mem_req_t route_req;
  logic     route_rsp_valid;
  logic     route_rsp_ready;
  mem_rsp_t route_rsp;

  // Arbiter to request buffer
  logic     arb_req_valid;
  logic     arb_req_ready;
  mem_req_t arb_req;

  // Response buffer to arbiter
  logic     buf_rsp_valid;
  logic     buf_rsp_ready;
  mem_rsp_t buf_rsp;

  icache_route #(
    .CachedBase(CachedBase),
    .CachedSize(CachedSize)
  ) icache_route_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_req_i        (fetch_req_i),
    .fetch_addr_i       (fetch_addr_i),
    .ic_miss_valid_i    (ic_miss_valid_i),
    .ic_miss_ready_o    (ic_miss_ready_o),
    .ic_miss_i          (ic_miss_i),
    .ic_uc_valid_i      (ic_uc_valid_i),
    .ic_uc_ready_o      (ic_uc_ready_o),
    .ic_uc_i            (ic_uc_i),
    .ic_miss_rsp_valid_o(ic_miss_rsp_valid_o),
    .ic_uc_rsp_valid_o  (ic_uc_rsp_valid_o),
    .ic_rsp_ready_i     (ic_rsp_ready_i),
    .ic_rsp_o           (ic_rsp_o),
    .out_valid_o        (route_req_valid),
    .out_ready_i        (route_req_ready),
    .out_req_o          (route_req),
    .in_rsp_valid_i     (route_rsp_valid),
    .in_rsp_ready_o     (route_rsp_ready),
    .in_rsp_i           (route_rsp)
  );

  mem_arbiter mem_arbiter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ic_valid_i    (route_req_valid),
    .ic_ready_o    (route_req_ready),
    .ic_req_i      (route_req),
    .dc_valid_i    (dc_miss_valid_i),
    .dc_ready_o    (dc_miss_ready_o),
    .dc_req_i      (dc_miss_i),
    .req_valid_o   (arb_req_valid),
    .req_ready_i   (arb_req_ready),
    .req_o         (arb_req),
    .rsp_valid_i   (buf_rsp_valid),
    .rsp_ready_o   (buf_rsp_ready),
    .rsp_i         (buf_rsp),
    .ic_rsp_valid_o(route_rsp_valid),
    .ic_rsp_ready_i(route_rsp_ready),
    .ic_rsp_o      (route_rsp),
    .dc_rsp_valid_o(dc_rsp_valid_o),
    .dc_rsp_ready_i(dc_rsp_ready_i),
    .dc_rsp_o      (dc_rsp_o)
  );

  // One cycle of buffering on each memory direction
  mem_fifo #(
    .payload_t(mem_req_t)
  ) req_fifo_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (arb_req_valid),
    .in_ready_o (arb_req_ready),
    .in_data_i  (arb_req),
    .out_valid_o(mem_req_valid_o),
    .out_ready_i(mem_req_ready_i),
    .out_data_o (mem_req_o)
  );

  mem_fifo #(
    .payload_t(mem_rsp_t)
  ) rsp_fifo_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (mem_rsp_valid_i),
    .in_ready_o (mem_rsp_ready_o),
    .in_data_i  (mem_rsp_i),
    .out_valid_o(buf_rsp_valid),
    .out_ready_i(buf_rsp_ready),
    .out_data_o (buf_rsp)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 5 cycles and released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verif/tb_refill_subsys.sv
`timescale 1ns/100ps

module tb_refill_subsys;

  import mem_pkg::*;
  import cache_cfg_pkg::*;

  localparam int unsigned Seed           = 25105;
  localparam int unsigned NumSingle      = 12;
  localparam int unsigned NumMixed       = 24;
  // Three single-side tests plus two tests with both sides busy
  localparam int unsigned NumTxn         = 3 * NumSingle + 4 * NumMixed;
  localparam int unsigned WatchdogCycles = NumTxn * 40 + 200;
  localparam mem_addr_t   CachedFetch    = 32'h8000_1040;
  localparam mem_addr_t   UncachedFetch  = 32'h0000_3000;

  logic      clk, rst_n;
  logic      fetch_req;
  mem_addr_t fetch_addr;
  logic      ic_miss_valid, ic_miss_ready, ic_uc_valid, ic_uc_ready;
  mem_req_t  ic_miss, ic_uc;
  logic      ic_miss_rsp_valid, ic_uc_rsp_valid, ic_rsp_ready;
  mem_rsp_t  ic_rsp;
  logic      dc_miss_valid, dc_miss_ready, dc_rsp_valid, dc_rsp_ready;
  mem_req_t  dc_miss;
  mem_rsp_t  dc_rsp;
  logic      mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp;

  string       test_name;
  logic        fetch_nc;
  logic        fetch_set;
  logic        bp_on;
  int unsigned issued_cnt, mem_req_cnt, rsp_cnt;
  int unsigned ic_wait, dc_wait;

  // Outstanding work, per side, in issue order
  mem_addr_t ic_exp_q[$];
  mem_addr_t ic_mem_q[$];
  mem_req_t  dc_exp_q[$];
  mem_req_t  dc_mem_q[$];
  mem_req_t  mem_pend_q[$];

  logic ic_hs, dc_hs;
  assign ic_hs = (ic_miss_valid && ic_miss_ready) || (ic_uc_valid && ic_uc_ready);
  assign dc_hs = dc_miss_valid && dc_miss_ready;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  refill_subsys #(
    .CachedBase(DefCachedBase),
    .CachedSize(DefCachedSize)
  ) refill_subsys_inst (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .fetch_req_i        (fetch_req),
    .fetch_addr_i       (fetch_addr),
    .ic_miss_valid_i    (ic_miss_valid),
    .ic_miss_ready_o    (ic_miss_ready),
    .ic_miss_i          (ic_miss),
    .ic_uc_valid_i      (ic_uc_valid),
    .ic_uc_ready_o      (ic_uc_ready),
    .ic_uc_i            (ic_uc),
    .ic_miss_rsp_valid_o(ic_miss_rsp_valid),
    .ic_uc_rsp_valid_o  (ic_uc_rsp_valid),
    .ic_rsp_ready_i     (ic_rsp_ready),
    .ic_rsp_o           (ic_rsp),
    .dc_miss_valid_i    (dc_miss_valid),
    .dc_miss_ready_o    (dc_miss_ready),
    .dc_miss_i          (dc_miss),
    .dc_rsp_valid_o     (dc_rsp_valid),
    .dc_rsp_ready_i     (dc_rsp_ready),
    .dc_rsp_o           (dc_rsp),
    .mem_req_valid_o    (mem_req_valid),
    .mem_req_ready_i    (mem_req_ready),
    .mem_req_o          (mem_req),
    .mem_rsp_valid_i    (mem_rsp_valid),
    .mem_rsp_ready_o    (mem_rsp_ready),
    .mem_rsp_i          (mem_rsp)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Memory contents with the low word as the address xor a constant
  // and the high word as the half-swapped address plus an offset
  function automatic mem_data_t exp_data(mem_addr_t addr);
    return {{addr[15:0], addr[31:16]} + 32'h1357_9bdf, addr ^ 32'ha5a5_5a5a};
  endfunction

  // Tag-aligned fetch address outside [base, base + size) is uncached
  function automatic logic outside_region(mem_addr_t addr);
    logic [MemAddrWidth:0] pa;
    logic [MemAddrWidth:0] lo;
    logic [MemAddrWidth:0] hi;
    pa = {1'b0, addr[MemAddrWidth-1:IndexWidth], {IndexWidth{1'b0}}};
    lo = {1'b0, DefCachedBase};
    hi = lo + {1'b0, DefCachedSize};
    return (pa < lo) || (pa >= hi);
  endfunction

  task automatic end_with_failure();
    $display("Errors found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_req(input string what, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  task automatic compare_rsp(input string what, input mem_rsp_t exp, input mem_rsp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic set_fetch(input mem_addr_t addr);
    @(negedge clk);
    fetch_req  = 1'b1;
    fetch_addr = addr;
    fetch_nc   = outside_region(addr);
    fetch_set  = 1'b1;
    @(negedge clk);
    fetch_req  = 1'b0;
  endtask

  // Instruction reads land in or out of the region to match the fetch
  task automatic send_ic_reads(input int unsigned n);
    mem_req_t  req;
    mem_addr_t rnd;
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk);
      rnd      = $urandom;
      req.addr = {(fetch_nc ? 2'b00 : 2'b10), rnd[29:3], 3'b000};
      // Garbage id that the arbiter must replace
      req.id   = rnd[MemIdWidth-1:0];
      if (fetch_nc) begin
        ic_uc       = req;
        ic_uc_valid = 1'b1;
      end else begin
        ic_miss       = req;
        ic_miss_valid = 1'b1;
      end
      do @(posedge clk); while (!(fetch_nc ? ic_uc_ready : ic_miss_ready));
      ic_exp_q.push_back(req.addr);
      ic_mem_q.push_back(req.addr);
      issued_cnt++;
    end
    @(negedge clk);
    ic_uc_valid   = 1'b0;
    ic_miss_valid = 1'b0;
  endtask

  task automatic send_dc_misses(input int unsigned n);
    mem_req_t  req;
    mem_addr_t rnd;
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk);
      rnd      = $urandom;
      req.addr = {rnd[31:3], 3'b000};
      req.id   = {1'b0, rnd[MemIdWidth-2:0]};
      dc_miss       = req;
      dc_miss_valid = 1'b1;
      do @(posedge clk); while (!dc_miss_ready);
      dc_exp_q.push_back(req);
      dc_mem_q.push_back(req);
      issued_cnt++;
    end
    @(negedge clk);
    dc_miss_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (ic_exp_q.size() != 0 || dc_exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(Seed));
    fetch_req     = 1'b0;
    fetch_addr    = '0;
    ic_miss_valid = 1'b0;
    ic_miss       = '0;
    ic_uc_valid   = 1'b0;
    ic_uc         = '0;
    dc_miss_valid = 1'b0;
    dc_miss       = '0;
    fetch_nc      = 1'b1;
    fetch_set     = 1'b0;
    bp_on         = 1'b0;
    issued_cnt    = 0;
    mem_req_cnt   = 0;
    rsp_cnt       = 0;
    ic_wait       = 0;
    dc_wait       = 0;
    test_name     = "reset";
    @(posedge rst_n);
    @(posedge clk);
    compare_bit("mem_req_valid_o", 1'b0, mem_req_valid);
    compare_bit("ic_miss_rsp_valid_o", 1'b0, ic_miss_rsp_valid);
    compare_bit("ic_uc_rsp_valid_o", 1'b0, ic_uc_rsp_valid);
    compare_bit("dc_rsp_valid_o", 1'b0, dc_rsp_valid);
    compare_bit("mem_rsp_ready_o", 1'b1, mem_rsp_ready);

    test_name = "cacheable_fetch";
    set_fetch(CachedFetch);
    send_ic_reads(NumSingle);
    wait_idle();

    test_name = "uncached_fetch";
    set_fetch(UncachedFetch);
    send_ic_reads(NumSingle);
    wait_idle();

    test_name = "data_miss";
    send_dc_misses(NumSingle);
    wait_idle();

    test_name = "concurrent";
    set_fetch(CachedFetch);
    fork
      send_ic_reads(NumMixed);
      send_dc_misses(NumMixed);
    join
    wait_idle();

    test_name = "back_pressure";
    bp_on = 1'b1;
    set_fetch(UncachedFetch);
    fork
      send_ic_reads(NumMixed);
      send_dc_misses(NumMixed);
    join
    wait_idle();
    bp_on = 1'b0;

    if (mem_req_cnt != issued_cnt || rsp_cnt != issued_cnt) begin
      $display("Transfer counts differ: %0d issued, %0d at memory, %0d responses",
               issued_cnt, mem_req_cnt, rsp_cnt);
      end_with_failure();
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // Readies toggle only during the back-pressure test
  initial begin
    mem_req_ready = 1'b1;
    ic_rsp_ready  = 1'b1;
    dc_rsp_ready  = 1'b1;
    forever begin
      @(negedge clk);
      if (bp_on) begin
        mem_req_ready = $urandom_range(0, 1);
        ic_rsp_ready  = $urandom_range(0, 1);
        dc_rsp_ready  = $urandom_range(0, 1);
      end else begin
        mem_req_ready = 1'b1;
        ic_rsp_ready  = 1'b1;
        dc_rsp_ready  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Memory model and checkers
  ////////////////////////////////////////

  // In-order answers after a random delay
  initial begin
    mem_rsp_valid = 1'b0;
    mem_rsp       = '0;
    forever begin
      @(negedge clk);
      mem_rsp_valid = 1'b0;
      if (mem_pend_q.size() != 0) begin
        repeat ($urandom_range(0, 3)) @(negedge clk);
        mem_rsp.data  = exp_data(mem_pend_q[0].addr);
        mem_rsp.id    = mem_pend_q[0].id;
        mem_rsp_valid = 1'b1;
        void'(mem_pend_q.pop_front());
        do @(posedge clk); while (!mem_rsp_ready);
      end
    end
  end

  always @(posedge clk) begin : req_monitor
    mem_req_t exp_req;
    if (rst_n && mem_req_valid && mem_req_ready) begin
      // Top id bit marks the instruction side
      if (mem_req.id[MemIdWidth-1]) begin
        if (ic_mem_q.size() == 0) begin
          $display("Instruction request reached memory but none was issued");
          end_with_failure();
        end
        exp_req.addr = ic_mem_q.pop_front();
        exp_req.id   = ICacheRdId;
      end else begin
        if (dc_mem_q.size() == 0) begin
          $display("Data request reached memory but none was issued");
          end_with_failure();
        end
        exp_req = dc_mem_q.pop_front();
      end
      compare_req("memory request", exp_req, mem_req);
      mem_pend_q.push_back(mem_req);
      mem_req_cnt++;
    end
  end

  always @(posedge clk) begin : rsp_checker
    mem_rsp_t exp_rsp;
    mem_req_t dc_req;
    if (rst_n && (ic_miss_rsp_valid || ic_uc_rsp_valid) && ic_rsp_ready) begin
      if (ic_exp_q.size() == 0) begin
        $display("Instruction response arrived with nothing outstanding");
        end_with_failure();
      end
      compare_bit("uncached response channel", fetch_nc, ic_uc_rsp_valid);
      exp_rsp.data = exp_data(ic_exp_q.pop_front());
      exp_rsp.id   = ICacheRdId;
      compare_rsp("instruction response", exp_rsp, ic_rsp);
      rsp_cnt++;
    end
    if (rst_n && dc_rsp_valid && dc_rsp_ready) begin
      if (dc_exp_q.size() == 0) begin
        $display("Data response arrived with nothing outstanding");
        end_with_failure();
      end
      dc_req       = dc_exp_q.pop_front();
      exp_rsp.data = exp_data(dc_req.addr);
      exp_rsp.id   = dc_req.id;
      compare_rsp("data response", exp_rsp, dc_rsp);
      rsp_cnt++;
    end
  end

  // Idle channel stays shut and no side waits behind two of the other
  always @(posedge clk) begin
    if (rst_n && fetch_set) begin
      if (fetch_nc) begin
        compare_bit("miss ready while uncached", 1'b0, ic_miss_ready);
        compare_bit("miss response valid while uncached", 1'b0, ic_miss_rsp_valid);
      end else begin
        compare_bit("uncached ready while cacheable", 1'b0, ic_uc_ready);
        compare_bit("uncached response valid while cacheable", 1'b0, ic_uc_rsp_valid);
      end
      if (ic_hs || !(ic_miss_valid || ic_uc_valid)) begin
        ic_wait = 0;
      end else if (dc_hs) begin
        ic_wait++;
      end
      if (dc_hs || !dc_miss_valid) begin
        dc_wait = 0;
      end else if (ic_hs) begin
        dc_wait++;
      end
      if (ic_wait > 1 || dc_wait > 1) begin
        $display("One side waited behind more than one request of the other");
        end_with_failure();
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout after %0d cycles, transfers did not complete", WatchdogCycles);
    end_with_failure();
  end

endmodule

// File: refill_subsys.f
common/mem_pkg.sv
common/cache_cfg_pkg.sv
mem_arbiter/mem_fifo.sv
mem_arbiter/mem_arbiter.sv
src/icache_route.sv
src/refill_subsys.sv
verif/tb_clk_gen.sv
verif/tb_refill_subsys.sv

// File: Bender.yml
package:
  name: refill_subsys

sources:
  # Shared packages
  - common/mem_pkg.sv
  - common/cache_cfg_pkg.sv
  # Design
  - mem_arbiter/mem_fifo.sv
  - mem_arbiter/mem_arbiter.sv
  - src/icache_route.sv
  - src/refill_subsys.sv
  # Testbench
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_refill_subsys.sv
